// ==== src/valu_pkg.sv ====
package valu_pkg;

  // widths
  localparam int VLEN            = 128;
  localparam int BYTE_WIDTH      = 8;
  localparam int HWORD_WIDTH     = 16;
  localparam int WORD_WIDTH      = 32;
  localparam int VLENB           = VLEN / BYTE_WIDTH;
  localparam int XLEN            = 32;
  localparam int ROB_DEPTH_WIDTH = 4;
  localparam int UOP_INDEX_WIDTH = 3;

  typedef logic [VLEN-1:0]            vreg_t;
  typedef logic [XLEN-1:0]            xreg_t;
  typedef logic [VLENB-1:0]           mask_t;
  typedef logic [ROB_DEPTH_WIDTH-1:0] rob_entry_t;
  typedef logic [UOP_INDEX_WIDTH-1:0] uop_index_t;
  typedef logic [5:0]                 funct6_t;
  typedef logic [2:0]                 funct3_t;
  typedef logic [4:0]                 vs1_field_t;

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32
  } eew_e;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MINU,
    OP_MIN,
    OP_MAXU,
    OP_MAX,
    OP_MOVE,
    OP_MERGE,
    OP_ZEXT2,
    OP_SEXT2,
    OP_ZEXT4,
    OP_SEXT4
  } alu_op_e;

  // funct3 categories
  localparam funct3_t OPIVV = 3'b000;
  localparam funct3_t OPIVX = 3'b100;
  localparam funct3_t OPMVV = 3'b010;

  // funct6 codes
  localparam funct6_t VMINU      = 6'b000100;
  localparam funct6_t VMIN       = 6'b000101;
  localparam funct6_t VMAXU      = 6'b000110;
  localparam funct6_t VMAX       = 6'b000111;
  localparam funct6_t VMERGE_VMV = 6'b010111;
  localparam funct6_t VXUNARY0   = 6'b010010;

  // vs1 field of VXUNARY0
  localparam vs1_field_t VZEXT_VF4 = 5'b00100;
  localparam vs1_field_t VSEXT_VF4 = 5'b00101;
  localparam vs1_field_t VZEXT_VF2 = 5'b00110;
  localparam vs1_field_t VSEXT_VF2 = 5'b00111;

endpackage

// ==== src/valu_minmax.sv ====
`timescale 1ns/1ns

module valu_minmax (
  input  valu_pkg::alu_op_e  op,
  input  valu_pkg::eew_e     eew,
  input  valu_pkg::vreg_t    src1,
  input  valu_pkg::vreg_t    src2,
  output valu_pkg::vreg_t    result
);
  import valu_pkg::*;

  vreg_t res8;
  vreg_t res16;
  vreg_t res32;

  // extra top bit makes one signed compare serve both forms
  always_comb begin
    logic                         is_signed;
    logic                         want_max;
    logic signed [BYTE_WIDTH:0]   a8, b8;
    logic signed [HWORD_WIDTH:0]  a16, b16;
    logic signed [WORD_WIDTH:0]   a32, b32;

    is_signed = (op == OP_MIN) || (op == OP_MAX);
    want_max  = (op == OP_MAXU) || (op == OP_MAX);

    for (int i = 0; i < VLEN/BYTE_WIDTH; i++) begin
      a8 = {is_signed & src2[i*BYTE_WIDTH+BYTE_WIDTH-1], src2[i*BYTE_WIDTH +: BYTE_WIDTH]};
      b8 = {is_signed & src1[i*BYTE_WIDTH+BYTE_WIDTH-1], src1[i*BYTE_WIDTH +: BYTE_WIDTH]};
      res8[i*BYTE_WIDTH +: BYTE_WIDTH] = ((a8 < b8) ^ want_max) ?
        src2[i*BYTE_WIDTH +: BYTE_WIDTH] : src1[i*BYTE_WIDTH +: BYTE_WIDTH];
    end

    for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
      a16 = {is_signed & src2[i*HWORD_WIDTH+HWORD_WIDTH-1], src2[i*HWORD_WIDTH +: HWORD_WIDTH]};
      b16 = {is_signed & src1[i*HWORD_WIDTH+HWORD_WIDTH-1], src1[i*HWORD_WIDTH +: HWORD_WIDTH]};
      res16[i*HWORD_WIDTH +: HWORD_WIDTH] = ((a16 < b16) ^ want_max) ?
        src2[i*HWORD_WIDTH +: HWORD_WIDTH] : src1[i*HWORD_WIDTH +: HWORD_WIDTH];
    end

    for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
      a32 = {is_signed & src2[i*WORD_WIDTH+WORD_WIDTH-1], src2[i*WORD_WIDTH +: WORD_WIDTH]};
      b32 = {is_signed & src1[i*WORD_WIDTH+WORD_WIDTH-1], src1[i*WORD_WIDTH +: WORD_WIDTH]};
      res32[i*WORD_WIDTH +: WORD_WIDTH] = ((a32 < b32) ^ want_max) ?
        src2[i*WORD_WIDTH +: WORD_WIDTH] : src1[i*WORD_WIDTH +: WORD_WIDTH];
    end
  end

  always_comb begin
    case (eew)
      EEW8:    result = res8;
      EEW16:   result = res16;
      default: result = res32;
    endcase
  end

endmodule

// ==== src/valu_operand_stage.sv ====
`timescale 1ns/1ns

module valu_operand_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  output logic                  uop_ready,
  input  valu_pkg::rob_entry_t  rob_entry,
  input  valu_pkg::funct6_t     funct6,
  input  valu_pkg::funct3_t     funct3,
  input  valu_pkg::vs1_field_t  vs1_field,
  input  logic                  vm,
  input  valu_pkg::uop_index_t  uop_index,
  input  valu_pkg::eew_e        eew,
  input  valu_pkg::vreg_t       v0_data,
  input  valu_pkg::vreg_t       vs1_data,
  input  valu_pkg::vreg_t       vs2_data,
  input  valu_pkg::xreg_t       rs1_data,
  output logic                  op_valid,
  input  logic                  op_ready,
  output valu_pkg::alu_op_e     op,
  output valu_pkg::eew_e        op_eew,
  output valu_pkg::rob_entry_t  op_rob_entry,
  output valu_pkg::mask_t       op_mask,
  output valu_pkg::vreg_t       op_src1,
  output valu_pkg::vreg_t       op_src2
);
  import valu_pkg::*;

  localparam int OFS_WIDTH = $clog2(VLEN);

  alu_op_e               dec_op;
  vreg_t                 src1_sel;
  vreg_t                 src2_sel;
  logic [OFS_WIDTH-1:0]  mask_offset;
  logic                  uop_fire;

  always_comb begin
    dec_op = OP_NONE;
    case (funct3)
      OPIVV, OPIVX: begin
        case (funct6)
          VMINU:      dec_op = OP_MINU;
          VMIN:       dec_op = OP_MIN;
          VMAXU:      dec_op = OP_MAXU;
          VMAX:       dec_op = OP_MAX;
          VMERGE_VMV: dec_op = vm ? OP_MOVE : OP_MERGE;
          default:    dec_op = OP_NONE;
        endcase
      end
      OPMVV: begin
        // extension only for legal source widths
        if (funct6 == VXUNARY0) begin
          case (vs1_field)
            VZEXT_VF2: if (eew == EEW8 || eew == EEW16) dec_op = OP_ZEXT2;
            VSEXT_VF2: if (eew == EEW8 || eew == EEW16) dec_op = OP_SEXT2;
            VZEXT_VF4: if (eew == EEW8) dec_op = OP_ZEXT4;
            VSEXT_VF4: if (eew == EEW8) dec_op = OP_SEXT4;
            default:   dec_op = OP_NONE;
          endcase
        end
      end
      default: dec_op = OP_NONE;
    endcase
  end

  // scalar broadcast for vx forms
  always_comb begin
    src1_sel = vs1_data;
    if (funct3 == OPIVX) begin
      case (eew)
        EEW8:    src1_sel = {(VLEN/BYTE_WIDTH){rs1_data[BYTE_WIDTH-1:0]}};
        EEW16:   src1_sel = {(VLEN/HWORD_WIDTH){rs1_data[HWORD_WIDTH-1:0]}};
        default: src1_sel = {(VLEN/WORD_WIDTH){rs1_data[WORD_WIDTH-1:0]}};
      endcase
    end
  end

  // extension source slice goes to the low bits
  always_comb begin
    case (dec_op)
      OP_ZEXT2, OP_SEXT2: src2_sel = vreg_t'(vs2_data[uop_index[0]*(VLEN/2) +: VLEN/2]);
      OP_ZEXT4, OP_SEXT4: src2_sel = vreg_t'(vs2_data[uop_index[1:0]*(VLEN/4) +: VLEN/4]);
      default:            src2_sel = vs2_data;
    endcase
  end

  // v0 slice starts at uop_index * VLEN/SEW
  always_comb begin
    case (eew)
      EEW8:    mask_offset = OFS_WIDTH'(uop_index) * OFS_WIDTH'(VLEN/BYTE_WIDTH);
      EEW16:   mask_offset = OFS_WIDTH'(uop_index) * OFS_WIDTH'(VLEN/HWORD_WIDTH);
      default: mask_offset = OFS_WIDTH'(uop_index) * OFS_WIDTH'(VLEN/WORD_WIDTH);
    endcase
  end

  assign uop_ready = !op_valid || op_ready;
  assign uop_fire  = uop_valid && uop_ready;

  // unsupported uops are swallowed here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid <= 1'b0;
    end else if (uop_fire) begin
      op_valid <= (dec_op != OP_NONE);
    end else if (op_ready) begin
      op_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_fire) begin
      op           <= dec_op;
      op_eew       <= eew;
      op_rob_entry <= rob_entry;
      op_mask      <= v0_data[mask_offset +: VLENB];
      op_src1      <= src1_sel;
      op_src2      <= src2_sel;
    end
  end

endmodule

// ==== src/valu_exec_stage.sv ====
`timescale 1ns/1ns

module valu_exec_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  op_valid,
  output logic                  op_ready,
  input  valu_pkg::alu_op_e     op,
  input  valu_pkg::eew_e        op_eew,
  input  valu_pkg::rob_entry_t  op_rob_entry,
  input  valu_pkg::mask_t       op_mask,
  input  valu_pkg::vreg_t       op_src1,
  input  valu_pkg::vreg_t       op_src2,
  output logic                  result_valid,
  input  logic                  result_ready,
  output valu_pkg::rob_entry_t  result_rob_entry,
  output valu_pkg::vreg_t       result_data,
  output logic                  result_ignore_vma
);
  import valu_pkg::*;

  vreg_t minmax_data;
  vreg_t merge_data;
  vreg_t ext_data;
  vreg_t next_data;
  logic  op_fire;

  valu_minmax u_minmax (
    .op     (op),
    .eew    (op_eew),
    .src1   (op_src1),
    .src2   (op_src2),
    .result (minmax_data)
  );

  // per byte, pick the mask bit of the element it belongs to
  always_comb begin
    logic sel;

    for (int b = 0; b < VLENB; b++) begin
      case (op_eew)
        EEW8:    sel = op_mask[b];
        EEW16:   sel = op_mask[b/2];
        default: sel = op_mask[b/4];
      endcase
      merge_data[b*BYTE_WIDTH +: BYTE_WIDTH] = sel ? op_src1[b*BYTE_WIDTH +: BYTE_WIDTH] :
                                                     op_src2[b*BYTE_WIDTH +: BYTE_WIDTH];
    end
  end

  // source slice sits in the low bits of op_src2
  always_comb begin
    logic sext;

    sext     = (op == OP_SEXT2) || (op == OP_SEXT4);
    ext_data = '0;
    if (op == OP_ZEXT4 || op == OP_SEXT4) begin
      for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
        ext_data[i*WORD_WIDTH +: WORD_WIDTH] =
          {{(WORD_WIDTH-BYTE_WIDTH){sext & op_src2[i*BYTE_WIDTH+BYTE_WIDTH-1]}},
           op_src2[i*BYTE_WIDTH +: BYTE_WIDTH]};
      end
    end else if (op_eew == EEW8) begin
      for (int i = 0; i < VLEN/HWORD_WIDTH; i++) begin
        ext_data[i*HWORD_WIDTH +: HWORD_WIDTH] =
          {{(HWORD_WIDTH-BYTE_WIDTH){sext & op_src2[i*BYTE_WIDTH+BYTE_WIDTH-1]}},
           op_src2[i*BYTE_WIDTH +: BYTE_WIDTH]};
      end
    end else begin
      for (int i = 0; i < VLEN/WORD_WIDTH; i++) begin
        ext_data[i*WORD_WIDTH +: WORD_WIDTH] =
          {{(WORD_WIDTH-HWORD_WIDTH){sext & op_src2[i*HWORD_WIDTH+HWORD_WIDTH-1]}},
           op_src2[i*HWORD_WIDTH +: HWORD_WIDTH]};
      end
    end
  end

  always_comb begin
    case (op)
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX:     next_data = minmax_data;
      OP_MOVE:                              next_data = op_src1;
      OP_MERGE:                             next_data = merge_data;
      OP_ZEXT2, OP_SEXT2, OP_ZEXT4, OP_SEXT4: next_data = ext_data;
      default:                              next_data = '0;
    endcase
  end

  assign op_ready = !result_valid || result_ready;
  assign op_fire  = op_valid && op_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else if (op_fire) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_fire) begin
      result_rob_entry  <= op_rob_entry;
      result_data       <= next_data;
      result_ignore_vma <= (op == OP_MERGE);
    end
  end

endmodule

// ==== src/valu_top.sv ====
`timescale 1ns/1ns

module valu_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  output logic                  uop_ready,
  input  valu_pkg::rob_entry_t  rob_entry,
  input  valu_pkg::funct6_t     funct6,
  input  valu_pkg::funct3_t     funct3,
  input  valu_pkg::vs1_field_t  vs1_field,
  input  logic                  vm,
  input  valu_pkg::uop_index_t  uop_index,
  input  valu_pkg::eew_e        eew,
  input  valu_pkg::vreg_t       v0_data,
  input  valu_pkg::vreg_t       vs1_data,
  input  valu_pkg::vreg_t       vs2_data,
  input  valu_pkg::xreg_t       rs1_data,
  output logic                  result_valid,
  input  logic                  result_ready,
  output valu_pkg::rob_entry_t  result_rob_entry,
  output valu_pkg::vreg_t       result_data,
  output logic                  result_ignore_vma
);
  import valu_pkg::*;

  // stage 1 to stage 2
  logic        op_valid;
  logic        op_ready;
  alu_op_e     op;
  eew_e        op_eew;
  rob_entry_t  op_rob_entry;
  mask_t       op_mask;
  vreg_t       op_src1;
  vreg_t       op_src2;

  valu_operand_stage u_operand (
    .clk          (clk),
    .arst_n       (arst_n),
    .uop_valid    (uop_valid),
    .uop_ready    (uop_ready),
    .rob_entry    (rob_entry),
    .funct6       (funct6),
    .funct3       (funct3),
    .vs1_field    (vs1_field),
    .vm           (vm),
    .uop_index    (uop_index),
    .eew          (eew),
    .v0_data      (v0_data),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .rs1_data     (rs1_data),
    .op_valid     (op_valid),
    .op_ready     (op_ready),
    .op           (op),
    .op_eew       (op_eew),
    .op_rob_entry (op_rob_entry),
    .op_mask      (op_mask),
    .op_src1      (op_src1),
    .op_src2      (op_src2)
  );

  valu_exec_stage u_exec (
    .clk               (clk),
    .arst_n            (arst_n),
    .op_valid          (op_valid),
    .op_ready          (op_ready),
    .op                (op),
    .op_eew            (op_eew),
    .op_rob_entry      (op_rob_entry),
    .op_mask           (op_mask),
    .op_src1           (op_src1),
    .op_src2           (op_src2),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

endmodule

// ==== tb/valu_chk.sv ====
`timescale 1ns/1ns

module valu_chk (
  input logic             clk,
  input logic             arst_n,
  input logic             uop_ready,
  input logic             op_valid,
  input logic             result_valid,
  input logic             result_ready,
  input valu_pkg::vreg_t  result_data
);

  // no result right after reset release
  a_idle_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !result_valid)
    else $error("result_valid high right after reset");

  // stalled result holds
  a_result_hold: assert property (@(posedge clk) disable iff (!arst_n)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else $error("result changed while stalled");

  // full pipeline stays full and closed while the stall lasts
  a_input_stall: assert property (@(posedge clk) disable iff (!arst_n)
    $past(result_valid && !result_ready && op_valid) && !result_ready |-> !uop_ready)
    else $error("uop_ready high while the full pipeline is still stalled");

endmodule

bind valu_top valu_chk u_chk (
  .clk          (clk),
  .arst_n       (arst_n),
  .uop_ready    (uop_ready),
  .op_valid     (op_valid),
  .result_valid (result_valid),
  .result_ready (result_ready),
  .result_data  (result_data)
);

// ==== tb/tb_valu.sv ====
`timescale 1ns/1ns

module tb_valu;
  import valu_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int RESET_CYCLES = 8;
  localparam int N_UOPS      = 216;

  logic        clk;
  logic        arst_n;
  logic        uop_valid;
  logic        uop_ready;
  rob_entry_t  rob_entry;
  funct6_t     funct6;
  funct3_t     funct3;
  vs1_field_t  vs1_field;
  logic        vm;
  uop_index_t  uop_index;
  eew_e        eew;
  vreg_t       v0_data;
  vreg_t       vs1_data;
  vreg_t       vs2_data;
  xreg_t       rs1_data;
  logic        result_valid;
  logic        result_ready;
  rob_entry_t  result_rob_entry;
  vreg_t       result_data;
  logic        result_ignore_vma;

  // expected results with the oldest in front
  rob_entry_t  exp_rob_q[$];
  vreg_t       exp_data_q[$];
  logic        exp_vma_q[$];
  int          exp_cycle_q[$];
  logic        exp_lat_q[$];

  int          cycle;
  int          errors;
  int          tests_pass;
  int          tests_fail;
  logic        bp_en;
  rob_entry_t  next_rob;

  valu_top u_dut (
    .clk               (clk),
    .arst_n            (arst_n),
    .uop_valid         (uop_valid),
    .uop_ready         (uop_ready),
    .rob_entry         (rob_entry),
    .funct6            (funct6),
    .funct3            (funct3),
    .vs1_field         (vs1_field),
    .vm                (vm),
    .uop_index         (uop_index),
    .eew               (eew),
    .v0_data           (v0_data),
    .vs1_data          (vs1_data),
    .vs2_data          (vs2_data),
    .rs1_data          (rs1_data),
    .result_valid      (result_valid),
    .result_ready      (result_ready),
    .result_rob_entry  (result_rob_entry),
    .result_data       (result_data),
    .result_ignore_vma (result_ignore_vma)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  always @(negedge clk) begin
    result_ready <= bp_en ? 1'($urandom) : 1'b1;
  end

  function automatic logic [31:0] get_elem(vreg_t v, int i, int w);
    vreg_t m;
    m = (vreg_t'(1) << w) - 1;
    return 32'((v >> (i*w)) & m);
  endfunction

  function automatic vreg_t put_elem(vreg_t v, int i, int w, logic [31:0] e);
    vreg_t m;
    m = ((vreg_t'(1) << w) - 1) << (i*w);
    return (v & ~m) | ((vreg_t'(e) << (i*w)) & m);
  endfunction

  function automatic vreg_t rand_vreg();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // reference model that returns 0 for uops without a result
  function automatic logic predict(funct6_t f6, funct3_t f3, vs1_field_t vf, logic m,
                                   uop_index_t idx, eew_e e, vreg_t v0, vreg_t s1,
                                   vreg_t s2, xreg_t rs1, output vreg_t res,
                                   output logic vma);
    int w;
    int n;
    int f;
    int base;
    logic sgn;
    logic mx;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] ka;
    logic [31:0] kb;
    vreg_t src1;

    w    = 8 << int'(e);
    n    = VLEN / w;
    res  = '0;
    vma  = 1'b0;
    src1 = s1;
    if (f3 == OPIVX) begin
      for (int i = 0; i < n; i++) src1 = put_elem(src1, i, w, rs1);
    end
    if ((f3 == OPIVV || f3 == OPIVX) && f6 >= VMINU && f6 <= VMAX) begin
      sgn = f6[0];
      mx  = f6[1];
      for (int i = 0; i < n; i++) begin
        a  = get_elem(s2, i, w);
        b  = get_elem(src1, i, w);
        ka = sgn ? a ^ (32'd1 << (w-1)) : a;
        kb = sgn ? b ^ (32'd1 << (w-1)) : b;
        res = put_elem(res, i, w, (mx ? (ka > kb) : (ka < kb)) ? a : b);
      end
      return 1'b1;
    end
    if ((f3 == OPIVV || f3 == OPIVX) && f6 == VMERGE_VMV) begin
      vma = !m;
      for (int i = 0; i < n; i++) begin
        res = put_elem(res, i, w, (m || v0[idx*n + i]) ? get_elem(src1, i, w)
                                                       : get_elem(s2, i, w));
      end
      return 1'b1;
    end
    if (f3 == OPMVV && f6 == VXUNARY0 && vf[4:2] == 3'b001) begin
      f = vf[1] ? 2 : 4;
      if ((f == 2 && e == EEW32) || (f == 4 && e != EEW8)) return 1'b0;
      base = (idx % f) * (n / f);
      for (int i = 0; i < n / f; i++) begin
        a = get_elem(s2, base + i, w);
        if (vf[0] && a[w-1]) a = a | ~((32'd1 << w) - 1);
        res = put_elem(res, i, w*f, a);
      end
      return 1'b1;
    end
    return 1'b0;
  endfunction

  task automatic send_uop(funct6_t f6, funct3_t f3, vs1_field_t vf, logic m,
                          uop_index_t idx, eew_e e);
    vreg_t exp_data;
    logic  exp_vma;
    logic  ok;

    @(negedge clk);
    uop_valid = 1'b1;
    rob_entry = next_rob;
    funct6    = f6;
    funct3    = f3;
    vs1_field = vf;
    vm        = m;
    uop_index = idx;
    eew       = e;
    v0_data   = rand_vreg();
    vs1_data  = rand_vreg();
    vs2_data  = rand_vreg();
    rs1_data  = $urandom;
    #1;
    while (!uop_ready) begin
      @(negedge clk);
      #1;
    end
    ok = predict(f6, f3, vf, m, idx, e, v0_data, vs1_data, vs2_data, rs1_data,
                 exp_data, exp_vma);
    if (ok) begin
      exp_rob_q.push_back(next_rob);
      exp_data_q.push_back(exp_data);
      exp_vma_q.push_back(exp_vma);
      exp_cycle_q.push_back(cycle);
      exp_lat_q.push_back(!bp_en);
    end
    next_rob = next_rob + 1'b1;
  endtask

  task automatic drain();
    @(negedge clk);
    uop_valid = 1'b0;
    while (exp_rob_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);
  endtask

  // results are checked in the cycle before their transfer edge
  always @(negedge clk) begin
    #2;
    if (arst_n && result_valid && result_ready) begin
      assert (exp_rob_q.size() != 0) else begin
        $display("result with tag %0d arrived with no uop outstanding at %0t",
                 result_rob_entry, $time);
        errors++;
      end
      if (exp_rob_q.size() != 0) begin
        assert (result_rob_entry == exp_rob_q[0]) else begin
          $display("[FAIL] %0t result_rob_entry exp %0d got %0d", $time,
                   exp_rob_q[0], result_rob_entry);
          errors++;
        end
        assert (result_data == exp_data_q[0]) else begin
          $display("[FAIL] %0t result_data exp %h got %h", $time, exp_data_q[0],
                   result_data);
          errors++;
        end
        assert (result_ignore_vma == exp_vma_q[0]) else begin
          $display("[FAIL] %0t result_ignore_vma exp %0b got %0b", $time,
                   exp_vma_q[0], result_ignore_vma);
          errors++;
        end
        assert (!exp_lat_q[0] || cycle - exp_cycle_q[0] == 2) else begin
          $display("[FAIL] %0t result_valid latency exp 2 got %0d", $time,
                   cycle - exp_cycle_q[0]);
          errors++;
        end
        void'(exp_rob_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_vma_q.pop_front());
        void'(exp_cycle_q.pop_front());
        void'(exp_lat_q.pop_front());
      end
    end
  end

  task automatic report_test(string name, int start_errors);
    if (errors == start_errors) begin
      $display("test %s: ok", name);
      tests_pass++;
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
      tests_fail++;
    end
  endtask

  task automatic minmax_uops();
    int e0;
    e0 = errors;
    for (int r = 0; r < 2; r++) begin
      for (int x = 0; x < 2; x++) begin
        for (int k = 0; k < 4; k++) begin
          for (int e = 0; e < 3; e++) begin
            send_uop(VMINU + funct6_t'(k), x ? OPIVX : OPIVV, 5'd0, 1'b1, 3'd0, eew_e'(e));
          end
        end
      end
    end
    drain();
    report_test("minmax", e0);
  endtask

  task automatic move_and_merge();
    int e0;
    e0 = errors;
    for (int e = 0; e < 3; e++) begin
      for (int i = 0; i < 8; i++) begin
        send_uop(VMERGE_VMV, OPIVV, 5'd0, 1'b1, uop_index_t'(i), eew_e'(e));
        send_uop(VMERGE_VMV, i[0] ? OPIVX : OPIVV, 5'd0, 1'b0, uop_index_t'(i), eew_e'(e));
      end
    end
    drain();
    report_test("move_merge", e0);
  endtask

  task automatic extend_slices();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      send_uop(VXUNARY0, OPMVV, VZEXT_VF2, 1'b1, uop_index_t'(i), EEW8);
      send_uop(VXUNARY0, OPMVV, VSEXT_VF2, 1'b1, uop_index_t'(i), EEW8);
      send_uop(VXUNARY0, OPMVV, VZEXT_VF2, 1'b1, uop_index_t'(i), EEW16);
      send_uop(VXUNARY0, OPMVV, VSEXT_VF2, 1'b1, uop_index_t'(i), EEW16);
      send_uop(VXUNARY0, OPMVV, VZEXT_VF4, 1'b1, uop_index_t'(i), EEW8);
      send_uop(VXUNARY0, OPMVV, VSEXT_VF4, 1'b1, uop_index_t'(i), EEW8);
    end
    drain();
    report_test("extension", e0);
  endtask

  task automatic drop_unsupported();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      send_uop(VMAX, OPIVV, 5'd0, 1'b1, 3'd0, EEW16);
      send_uop(VXUNARY0, OPMVV, i[0] ? VSEXT_VF4 : VZEXT_VF4, 1'b1, uop_index_t'(i), EEW16);
      send_uop(VMERGE_VMV, OPIVV, 5'd0, 1'b0, uop_index_t'(i), EEW8);
      send_uop(6'b111111, OPIVV, 5'd0, 1'b1, 3'd0, EEW32);
    end
    drain();
    report_test("unsupported", e0);
  endtask

  task automatic stall_results();
    int e0;
    int k;
    e0    = errors;
    bp_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      k = $urandom % 3;
      case (k)
        0: send_uop(VMINU + funct6_t'($urandom % 4), ($urandom % 2) ? OPIVX : OPIVV,
                    5'd0, 1'b1, 3'd0, eew_e'($urandom % 3));
        1: send_uop(VMERGE_VMV, OPIVV, 5'd0, 1'b0, uop_index_t'($urandom), EEW16);
        default: send_uop(VXUNARY0, OPMVV, VSEXT_VF2, 1'b1, uop_index_t'($urandom), EEW8);
      endcase
    end
    drain();
    bp_en = 1'b0;
    report_test("backpressure", e0);
  endtask

  initial begin
    #((N_UOPS*10 + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: the DUT stopped delivering results");
    $display("sim failed");
    $finish;
  end

  initial begin
    void'($urandom(61669));
    cycle      = 0;
    errors     = 0;
    tests_pass = 0;
    tests_fail = 0;
    bp_en      = 1'b0;
    next_rob   = '0;
    arst_n     = 1'b0;
    uop_valid  = 1'b0;
    rob_entry  = '0;
    funct6     = '0;
    funct3     = '0;
    vs1_field  = '0;
    vm         = 1'b1;
    uop_index  = '0;
    eew        = EEW8;
    v0_data    = '0;
    vs1_data   = '0;
    vs2_data   = '0;
    rs1_data   = '0;
    result_ready = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    minmax_uops();
    move_and_merge();
    extend_slices();
    drop_unsupported();
    stall_results();
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0 && tests_fail == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/valu_pkg.sv
src/valu_minmax.sv
src/valu_operand_stage.sv
src/valu_exec_stage.sv
src/valu_top.sv
tb/valu_chk.sv
tb/tb_valu.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_valu -f files.f -o tb_valu
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

./obj_dir/tb_valu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
  exit 0
fi
exit 1
